//--- logic/cpc_loader_pkg.sv
`default_nettype none

package cpc_loader_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    typedef logic [24:0] ioctl_addr_t;   // Host download byte address
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] ext_t;          // Two ASCII chars of extension
    typedef logic [7:0]  ioctl_index_t;
    typedef logic [8:0]  page_t;         // Expansion ROM page
    typedef logic [22:0] boot_addr_t;    // Address inside one bank
    typedef logic [1:0]  bank_t;
    typedef logic [63:0] rom_map_t;      // Upper ROM presence
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;

    //////////////////////////////
    // Constants
    //////////////////////////////

    // Download slots from the host menu
    localparam ioctl_index_t idx_rom = 8'd0;
    localparam ioctl_index_t idx_ext = 8'd3;
    localparam ioctl_index_t idx_dan = 8'd5;

    // ROM set layout, one 16 KB segment per slot
    localparam page_t slot_os     = 9'h000;
    localparam page_t slot_basic  = 9'h040;
    localparam page_t slot_amsdos = 9'h047;
    localparam page_t slot_mf2    = 9'h03F;

    localparam page_t page_malformed = 9'h1EE;   // Unused page, bad extension
    localparam page_t page_combo_end = 9'h1FF;   // Second block of a combo file

    localparam bank_t bank_dan = 2'd3;           // Cartridge bank

    localparam int queue_depth = 4;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef enum logic [1:0] {
        load_none,
        load_rom,
        load_ext,
        load_dan
    } load_kind_e;

    // Accepted download byte after the decoder
    typedef struct packed {
        load_kind_e  kind;
        ioctl_addr_t addr;
        byte_t       data;
        page_t       page;
        logic        combo;
    } dl_beat_s;

    // Mapped memory write
    typedef struct packed {
        bank_t      bank;
        boot_addr_t addr;
        byte_t      data;
    } mem_wr_s;

endpackage

`default_nettype wire

//--- logic/ext_page_decoder.sv
`default_nettype none

module ext_page_decoder (
    input  logic                         clk_sys,
    input  logic                         reset,
    input  logic                         model,
    input  logic                         ioctl_download,
    input  cpc_loader_pkg::ioctl_index_t ioctl_index,
    input  cpc_loader_pkg::ext_t         ioctl_file_ext,
    input  logic                         ioctl_wr,
    input  cpc_loader_pkg::ioctl_addr_t  ioctl_addr,
    input  cpc_loader_pkg::byte_t        ioctl_dout,
    input  logic                         ioctl_ready,
    input  logic                         combo_done,
    output cpc_loader_pkg::dl_beat_s     beat,
    output logic                         beat_valid,
    input  logic                         dan_unload,
    output logic                         dan_loaded
);
    import cpc_loader_pkg::*;

    load_kind_e kind;
    logic       download_q;
    logic       dan_q;
    logic       start;
    logic       accept;
    logic       model_q;     // Model when the file started
    logic       model_ok;
    logic [4:0] hi;          // {valid, nibble}
    logic [4:0] lo;
    page_t      ext_page;
    logic       ext_combo;
    page_t      page;
    page_t      page_next;
    logic       combo;
    logic       combo_next;

    function automatic logic [4:0] hex_nibble(input byte_t c);
        logic [4:0] r;
        r = 5'b0_0000;
        if (c >= "0" && c <= "9") begin
            r = {1'b1, c[3:0]};
        end else if (c >= "A" && c <= "F") begin
            r = {1'b1, c[3:0] + 4'd9};
        end
        return r;
    endfunction

    always_comb begin
        kind = load_none;
        if (ioctl_download) begin
            case (ioctl_index)
                idx_rom: kind = load_rom;
                idx_ext: kind = load_ext;
                idx_dan: kind = load_dan;
                default: kind = load_none;   // Other images ignored
            endcase
        end
    end

    assign start = ioctl_download & ~download_q;

    // An expansion file must land in one bank
    assign model_ok = (kind != load_ext) | start | (model == model_q);
    assign accept   = ioctl_wr & ioctl_ready & (kind != load_none) & model_ok;

    //////////////////////////////
    // Page from file extension
    //////////////////////////////

    always_comb begin
        hi = hex_nibble(ioctl_file_ext[15:8]);
        lo = hex_nibble(ioctl_file_ext[7:0]);
        ext_combo = 1'b0;
        if (ioctl_file_ext == "ZZ") begin
            ext_page = '0;
        end else if (ioctl_file_ext == "Z0") begin
            ext_page  = '0;
            ext_combo = 1'b1;   // Two blocks, second goes to the end page
        end else if (hi[4] && lo[4]) begin
            ext_page = {1'b0, hi[3:0], lo[3:0]};
        end else begin
            ext_page = page_malformed;
        end
    end

    // Next page is also used for the byte taken this cycle
    always_comb begin
        page_next  = page;
        combo_next = combo;
        if (start && kind == load_ext) begin
            page_next  = ext_page;
            combo_next = ext_combo;
        end else if (combo_done) begin
            page_next  = page_combo_end;
            combo_next = 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            download_q <= 1'b0;
            dan_q      <= 1'b0;
            model_q    <= 1'b0;
            page       <= '0;
            combo      <= 1'b0;
            beat_valid <= 1'b0;
            dan_loaded <= 1'b0;
        end else begin
            download_q <= ioctl_download;
            dan_q      <= (kind == load_dan);
            page       <= page_next;
            combo      <= combo_next;
            beat_valid <= accept;
            if (start) model_q <= model;
            if (dan_q && kind != load_dan) begin
                dan_loaded <= 1'b1;          // Cartridge download finished
            end else if (dan_unload) begin
                dan_loaded <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            beat.kind  <= kind;
            beat.addr  <= ioctl_addr;
            beat.data  <= ioctl_dout;
            beat.page  <= page_next;
            beat.combo <= combo_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/boot_addr_mapper.sv
`default_nettype none

module boot_addr_mapper (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     model,
    input  cpc_loader_pkg::dl_beat_s beat,
    input  logic                     beat_valid,
    output cpc_loader_pkg::mem_wr_s  wr,
    output logic                     wr_valid,
    output logic                     combo_done,
    output cpc_loader_pkg::rom_map_t rom_map
);
    import cpc_loader_pkg::*;

    mem_wr_s     map;
    logic        map_ok;
    logic [10:0] segment;    // 16 KB segment of the download

    assign segment = beat.addr[24:14];

    //////////////////////////////
    // Address mapping
    //////////////////////////////

    always_comb begin
        map.data        = beat.data;
        map.addr[13:0]  = beat.addr[13:0];   // Offset inside the 16 KB block
        map.addr[22:14] = '1;
        map.bank        = '0;
        map_ok          = beat_valid;

        case (beat.kind)
            load_rom: begin
                // 6128 set in bank 0, 664 set in bank 1
                map.bank = {1'b0, segment[2]};
                case (segment[1:0])
                    2'd0: map.addr[22:14] = slot_os;
                    2'd1: map.addr[22:14] = slot_basic;
                    2'd2: map.addr[22:14] = slot_amsdos;
                    default: map.addr[22:14] = slot_mf2;
                endcase
                if (segment[10:3] != '0) begin
                    map_ok = 1'b0;                  // Past the last slot
                end
            end
            load_ext: begin
                map.addr[22]    = beat.page[8];
                map.addr[21:14] = beat.page[7:0] + beat.addr[21:14];
                map.bank        = {1'b0, model};
            end
            load_dan: begin
                map.bank        = bank_dan;
                map.addr[22:14] = beat.addr[22:14];
            end
            default: begin
                map_ok = 1'b0;
            end
        endcase
    end

    // Last byte of a combo block moves the decoder to the end page
    assign combo_done = beat_valid & (beat.kind == load_ext) & beat.combo &
                        (&beat.addr[13:0]);

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= map_ok;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (map_ok) begin
            wr <= map;
        end
    end

    // Upper ROM slots filled by expansion files
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rom_map <= '0;
        end else if (beat_valid && beat.kind == load_ext && map.addr[20]) begin
            rom_map[map.addr[19:14]] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/boot_write_queue.sv
`default_nettype none

module boot_write_queue (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  cpc_loader_pkg::mem_wr_s   wr,
    input  logic                      wr_valid,
    output logic                      ioctl_ready,
    output logic                      idle,
    output logic                      awvalid,
    input  logic                      awready,
    output cpc_loader_pkg::axi_addr_t awaddr,
    output logic                      wvalid,
    input  logic                      wready,
    output cpc_loader_pkg::axi_data_t wdata,
    output logic [3:0]                wstrb,
    input  logic                      bvalid,
    output logic                      bready,
    input  logic [1:0]                bresp,
    output logic                      write_error
);
    import cpc_loader_pkg::*;

    typedef enum logic [1:0] {
        wq_idle,
        wq_send,     // Address and data channels open
        wq_resp      // Waiting for bresp
    } wq_state_e;

    wq_state_e                        state;
    mem_wr_s                          fifo_mem [queue_depth];
    mem_wr_s                          head;
    logic [$clog2(queue_depth)-1:0]   wr_ptr;
    logic [$clog2(queue_depth)-1:0]   rd_ptr;
    logic [$clog2(queue_depth):0]     count;
    logic                             pop;

    assign head = fifo_mem[rd_ptr];
    assign pop  = (state == wq_idle) && (count != '0);

    // Room for this byte plus two still in the pipeline
    assign ioctl_ready = (count <= queue_depth - 3);
    assign idle        = (count == '0) && (state == wq_idle) && !wr_valid;
    assign bready      = 1'b1;

    //////////////////////////////
    // FIFO
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (wr_valid) begin
            fifo_mem[wr_ptr] <= wr;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + wr_valid - pop;
        end
    end

    //////////////////////////////
    // AXI4-Lite write master
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state       <= wq_idle;
            awvalid     <= 1'b0;
            wvalid      <= 1'b0;
            write_error <= 1'b0;
        end else begin
            case (state)
                wq_idle: begin
                    if (pop) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= wq_send;
                    end
                end
                wq_send: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if ((awready || !awvalid) && (wready || !wvalid)) begin
                        state <= wq_resp;
                    end
                end
                default: begin
                    if (bvalid) begin
                        state <= wq_idle;
                        if (bresp != 2'b00) write_error <= 1'b1;   // Sticky
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pop) begin
            awaddr <= {7'd0, head.bank, head.addr};
            wdata  <= {4{head.data}};                // Byte on every lane
            wstrb  <= 4'b0001 << head.addr[1:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/cpc_image_loader.sv
`default_nettype none

module cpc_image_loader (
    input  logic                         clk_sys,
    input  logic                         reset,
    input  logic                         model,
    input  logic                         ioctl_download,
    input  cpc_loader_pkg::ioctl_index_t ioctl_index,
    input  cpc_loader_pkg::ext_t         ioctl_file_ext,
    input  logic                         ioctl_wr,
    input  cpc_loader_pkg::ioctl_addr_t  ioctl_addr,
    input  cpc_loader_pkg::byte_t        ioctl_dout,
    output logic                         ioctl_ready,
    input  logic                         dan_unload,
    output logic                         dan_loaded,
    output cpc_loader_pkg::rom_map_t     rom_map,
    output logic                         idle,
    output logic                         write_error,
    output logic                         awvalid,
    input  logic                         awready,
    output cpc_loader_pkg::axi_addr_t    awaddr,
    output logic                         wvalid,
    input  logic                         wready,
    output cpc_loader_pkg::axi_data_t    wdata,
    output logic [3:0]                   wstrb,
    input  logic                         bvalid,
    output logic                         bready,
    input  logic [1:0]                   bresp
);
    import cpc_loader_pkg::*;

    dl_beat_s beat;
    logic     beat_valid;
    mem_wr_s  wr;
    logic     wr_valid;
    logic     combo_done;

    // Stage 1, page and kind
    ext_page_decoder u_decoder (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .model          (model),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .ioctl_file_ext (ioctl_file_ext),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .ioctl_ready    (ioctl_ready),
        .combo_done     (combo_done),
        .beat           (beat),
        .beat_valid     (beat_valid),
        .dan_unload     (dan_unload),
        .dan_loaded     (dan_loaded)
    );

    // Stage 2, bank and address
    boot_addr_mapper u_mapper (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .model      (model),
        .beat       (beat),
        .beat_valid (beat_valid),
        .wr         (wr),
        .wr_valid   (wr_valid),
        .combo_done (combo_done),
        .rom_map    (rom_map)
    );

    boot_write_queue u_queue (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .wr          (wr),
        .wr_valid    (wr_valid),
        .ioctl_ready (ioctl_ready),
        .idle        (idle),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .write_error (write_error)
    );

endmodule

`default_nettype wire

//--- testbench/cpc_image_loader_assert.sv
`default_nettype none

module cpc_image_loader_assert (
    input logic                                        clk_sys,
    input logic                                        reset,
    input logic                                        awvalid,
    input logic                                        awready,
    input cpc_loader_pkg::axi_addr_t                   awaddr,
    input logic                                        wvalid,
    input logic                                        wready,
    input logic [3:0]                                  wstrb,
    input logic                                        ioctl_ready,
    input logic                                        wr_valid,
    input logic [$clog2(cpc_loader_pkg::queue_depth):0] count
);
    timeunit 1ns;
    timeprecision 100ps;
    import cpc_loader_pkg::*;

    int fail_count = 0;   // Assertion failures so far

    //////////////////////////////
    // AXI write channels
    //////////////////////////////

    a_aw_hold: assert property (@(posedge clk_sys) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            fail_count++;
            $error("awvalid or awaddr changed before awready");
        end

    a_w_hold: assert property (@(posedge clk_sys) disable iff (reset)
        wvalid && !wready |=> wvalid)
        else begin
            fail_count++;
            $error("wvalid dropped before wready");
        end

    a_wstrb_onehot: assert property (@(posedge clk_sys) disable iff (reset)
        wvalid |-> $onehot(wstrb))
        else begin
            fail_count++;
            $error("wstrb is not one-hot");
        end

    // Host stalled early enough that a full queue takes no write
    a_ready_full: assert property (@(posedge clk_sys) disable iff (reset)
        count == queue_depth |-> !ioctl_ready && !wr_valid)
        else begin
            fail_count++;
            $error("full queue with ioctl_ready high or a write arriving");
        end

endmodule

`default_nettype wire

//--- testbench/tb_cpc_image_loader.sv
`default_nettype none

module tb_cpc_image_loader;
    timeunit 1ns;
    timeprecision 100ps;
    import cpc_loader_pkg::*;

    localparam int clk_period      = 4;
    localparam int max_delay_limit = 8;     // Slowest AXI ready, in cycles
    localparam int total_bytes     = 100;   // Bytes sent over all tests, rounded up
    localparam int watchdog_ns     = total_bytes * (2 * max_delay_limit + 10) * clk_period * 2;

    logic         clk_sys;
    logic         reset;
    logic         model;
    logic         ioctl_download;
    ioctl_index_t ioctl_index;
    ext_t         ioctl_file_ext;
    logic         ioctl_wr;
    ioctl_addr_t  ioctl_addr;
    byte_t        ioctl_dout;
    logic         ioctl_ready;
    logic         dan_unload;
    logic         dan_loaded;
    rom_map_t     rom_map;
    logic         idle;
    logic         write_error;
    logic         awvalid;
    logic         awready;
    axi_addr_t    awaddr;
    logic         wvalid;
    logic         wready;
    axi_data_t    wdata;
    logic [3:0]   wstrb;
    logic         bvalid;
    logic         bready;
    logic [1:0]   bresp;

    int           max_delay;
    logic [1:0]   resp_mode;        // bresp returned by the slave model
    int unsigned  delay_pool [256];
    int           pool_idx;
    int           errors;
    int           tests_run;
    int           tests_failed;
    string        current_test;
    logic         saw_stall;
    rom_map_t     exp_map;
    mem_wr_s      exp_q [$];
    mem_wr_s      got_q [$];
    ioctl_addr_t  tx_addr [$];
    byte_t        tx_data [$];

    cpc_image_loader u_dut (.*);

    bind boot_write_queue cpc_image_loader_assert u_assert (
        .clk_sys(clk_sys), .reset(reset), .awvalid(awvalid), .awready(awready),
        .awaddr(awaddr), .wvalid(wvalid), .wready(wready), .wstrb(wstrb),
        .ioctl_ready(ioctl_ready), .wr_valid(wr_valid), .count(count)
    );

    always #(clk_period / 2) clk_sys = ~clk_sys;

    //////////////////////////////
    // AXI memory model
    //////////////////////////////

    task automatic wait_random_cycles();
        int d;
        d = delay_pool[pool_idx % 256] % (max_delay + 1);
        pool_idx++;
        repeat (d) begin
            @(posedge clk_sys);
            #1;
        end
    endtask

    initial begin : axi_slave
        mem_wr_s    rec;
        logic [3:0] exp_strb;
        forever begin
            @(posedge clk_sys);
            #1;
            if (awvalid && wvalid) begin
                rec.bank = awaddr[24:23];
                rec.addr = awaddr[22:0];
                rec.data = wdata[8 * awaddr[1:0] +: 8];   // Lane picked by the address
                exp_strb = 4'b0000;
                exp_strb[awaddr[1:0]] = 1'b1;
                if (wstrb !== exp_strb) begin
                    $display("Error: %s wstrb expected %b actual %b", current_test,
                             exp_strb, wstrb);
                    errors++;
                end
                if (wdata !== {4{rec.data}}) begin
                    $display("Error: %s wdata expected %h actual %h", current_test,
                             {4{rec.data}}, wdata);
                    errors++;
                end
                if (awaddr[31:25] !== '0) begin
                    $display("Error: %s awaddr upper bits expected 0 actual %h",
                             current_test, awaddr[31:25]);
                    errors++;
                end
                wait_random_cycles();
                awready = 1'b1;
                wready  = 1'b1;
                @(posedge clk_sys);
                #1;
                awready = 1'b0;
                wready  = 1'b0;
                got_q.push_back(rec);
                wait_random_cycles();
                bresp  = resp_mode;
                bvalid = 1'b1;
                if (bready !== 1'b1) begin
                    $display("Error: %s bready expected 1 actual %b", current_test, bready);
                    errors++;
                end
                @(posedge clk_sys);
                #1;
                bvalid = 1'b0;
                bresp  = 2'b00;
            end
        end
    end

    //////////////////////////////
    // Host download model
    //////////////////////////////

    task automatic send_byte(input ioctl_addr_t addr, input byte_t data);
        ioctl_addr = addr;
        ioctl_dout = data;
        ioctl_wr   = 1'b1;
        while (!ioctl_ready) begin   // Hold the byte while stalled
            saw_stall = 1'b1;
            @(posedge clk_sys);
            #1;
        end
        @(posedge clk_sys);
        #1;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (!idle && n < 1000) begin
            @(posedge clk_sys);
            #1;
            n++;
        end
        if (!idle) begin
            $display("Loader did not return to idle after a download");
            errors++;
        end
    endtask

    task automatic run_download(input ioctl_index_t index, input ext_t ext);
        ioctl_index    = index;
        ioctl_file_ext = ext;
        ioctl_download = 1'b1;
        foreach (tx_addr[i]) send_byte(tx_addr[i], tx_data[i]);
        ioctl_wr = 1'b0;
        @(posedge clk_sys);
        #1;
        ioctl_download = 1'b0;
        @(posedge clk_sys);
        #1;
        tx_addr.delete();
        tx_data.delete();
        wait_idle();
    endtask

    //////////////////////////////
    // Expected values and checks
    //////////////////////////////

    task automatic queue_byte(input ioctl_addr_t dl, input byte_t d);
        tx_addr.push_back(dl);
        tx_data.push_back(d);
    endtask

    task automatic expect_write(input bank_t bank, input page_t page, input ioctl_addr_t dl,
                                input byte_t d);
        mem_wr_s w;
        w.bank = bank;
        w.addr = {page, dl[13:0]};
        w.data = d;
        exp_q.push_back(w);
    endtask

    // Expansion byte lands at page plus segment, bank from model
    task automatic load_ext_byte(input page_t page, input ioctl_addr_t dl);
        byte_t d;
        page_t mapped;
        d      = byte_t'($urandom);
        mapped = {page[8], page[7:0] + dl[21:14]};
        queue_byte(dl, d);
        expect_write({1'b0, model}, mapped, dl, d);
        if (mapped[6]) exp_map[mapped[5:0]] = 1'b1;
    endtask

    function automatic page_t rom_slot(input int seg);
        case (seg % 4)
            0:       return slot_os;
            1:       return slot_basic;
            2:       return slot_amsdos;
            default: return slot_mf2;
        endcase
    endfunction

    task automatic check_results(input string name);
        if (got_q.size() != exp_q.size()) begin
            $display("Error: %s write count expected %0d actual %0d", name, exp_q.size(),
                     got_q.size());
            errors++;
        end
        foreach (exp_q[i]) begin
            if (i < got_q.size() && got_q[i] !== exp_q[i]) begin
                $display("Error: %s write %0d expected %0d:%h:%h actual %0d:%h:%h", name, i,
                         exp_q[i].bank, exp_q[i].addr, exp_q[i].data,
                         got_q[i].bank, got_q[i].addr, got_q[i].data);
                errors++;
            end
        end
        if (rom_map !== exp_map) begin
            $display("Error: %s rom_map expected %h actual %h", name, exp_map, rom_map);
            errors++;
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - start);
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic reset_values_test();
        int start;
        start        = errors;
        current_test = "reset_values";
        check_bit("reset_values awvalid", 1'b0, awvalid);
        check_bit("reset_values wvalid", 1'b0, wvalid);
        check_bit("reset_values write_error", 1'b0, write_error);
        check_bit("reset_values dan_loaded", 1'b0, dan_loaded);
        check_bit("reset_values ioctl_ready", 1'b1, ioctl_ready);
        check_bit("reset_values idle", 1'b1, idle);
        check_results("reset_values");
        report_test("reset_values", start);
    endtask

    task automatic rom_set_test();
        int          start;
        int          seg;
        int          k;
        ioctl_addr_t dl;
        byte_t       d;
        start        = errors;
        current_test = "rom_set";
        for (seg = 0; seg < 9; seg++) begin
            for (k = 0; k < 3; k++) begin
                dl = (ioctl_addr_t'(seg) << 14) | ((k == 0) ? 0 : (k == 1) ? 14'h1235 : 14'h3FFF);
                d  = byte_t'($urandom);
                queue_byte(dl, d);
                // Segment 8 is past the last slot
                if (seg < 8) expect_write(bank_t'(seg / 4), rom_slot(seg), dl, d);
            end
        end
        run_download(idx_rom, "  ");
        queue_byte(25'h000_0040, 8'hA5);   // Index 1 is not a loader image
        run_download(8'd1, "  ");
        check_results("rom_set");
        report_test("rom_set", start);
    endtask

    task automatic ext_pages_test();
        int start;
        start        = errors;
        current_test = "ext_pages";
        model = 1'b1;
        load_ext_byte(9'h007, 25'h000_0010);
        load_ext_byte(9'h007, 25'h000_8123);
        run_download(idx_ext, "07");
        model = 1'b0;
        load_ext_byte(9'h01A, 25'h000_0000);
        load_ext_byte(9'h01A, {11'h030, 14'h0042});   // Lands in the upper ROM range
        run_download(idx_ext, "1A");
        load_ext_byte(9'h1EE, 25'h000_0005);
        run_download(idx_ext, "G1");
        check_results("ext_pages");
        report_test("ext_pages", start);
    endtask

    task automatic combo_test();
        int start;
        start        = errors;
        current_test = "combo";
        model = 1'b0;
        load_ext_byte(9'h000, 25'h000_0000);
        load_ext_byte(9'h000, 25'h000_2000);
        load_ext_byte(9'h000, 25'h000_3FFF);
        load_ext_byte(9'h1FF, 25'h000_4000);   // Second block on the end page
        load_ext_byte(9'h1FF, 25'h000_5FFF);
        load_ext_byte(9'h1FF, 25'h000_7FFF);
        run_download(idx_ext, "Z0");
        check_results("combo");
        report_test("combo", start);
    endtask

    task automatic dandanator_test();
        int          start;
        int          k;
        ioctl_addr_t dl;
        byte_t       d;
        start        = errors;
        current_test = "dandanator";
        check_bit("dandanator loaded before download", 1'b0, dan_loaded);
        for (k = 0; k < 3; k++) begin
            dl = (k == 0) ? 25'h000_0000 : (k == 1) ? 25'h007_C123 : 25'h040_0005;
            d  = byte_t'($urandom);
            queue_byte(dl, d);
            expect_write(bank_dan, dl[22:14], dl, d);
        end
        run_download(idx_dan, "  ");
        check_bit("dandanator loaded after download", 1'b1, dan_loaded);
        dan_unload = 1'b1;
        @(posedge clk_sys);
        #1;
        dan_unload = 1'b0;
        check_bit("dandanator loaded after unload", 1'b0, dan_loaded);
        check_results("dandanator");
        report_test("dandanator", start);
    endtask

    task automatic backpressure_test();
        int start;
        int k;
        start        = errors;
        current_test = "backpressure";
        max_delay    = max_delay_limit;
        saw_stall    = 1'b0;
        model        = 1'b0;
        for (k = 0; k < 40; k++) load_ext_byte(9'h03C, ioctl_addr_t'(k));
        run_download(idx_ext, "3C");
        max_delay = 1;
        if (!saw_stall) begin
            $display("Host was never stalled during the slow AXI run");
            errors++;
        end
        check_results("backpressure");
        report_test("backpressure", start);
    endtask

    task automatic slave_error_test();
        int start;
        start        = errors;
        current_test = "slave_error";
        check_bit("slave_error before", 1'b0, write_error);
        resp_mode = 2'b10;
        queue_byte(25'h000_0010, 8'h5C);
        expect_write(2'd0, slot_os, 25'h000_0010, 8'h5C);
        run_download(idx_rom, "  ");
        resp_mode = 2'b00;
        check_bit("slave_error after", 1'b1, write_error);
        check_results("slave_error");
        report_test("slave_error", start);
    endtask

    initial begin : watchdog
        #(watchdog_ns);
        $display("Run stopped by the watchdog after %0d ns", watchdog_ns);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hb3d1_7fcf));
        foreach (delay_pool[i]) delay_pool[i] = $urandom;
        clk_sys        = 1'b0;
        reset          = 1'b1;
        model          = 1'b0;
        ioctl_download = 1'b0;
        ioctl_index    = '0;
        ioctl_file_ext = '0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        dan_unload     = 1'b0;
        awready        = 1'b0;
        wready         = 1'b0;
        bvalid         = 1'b0;
        bresp          = 2'b00;
        max_delay      = 1;
        resp_mode      = 2'b00;
        pool_idx       = 0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        current_test   = "";
        saw_stall      = 1'b0;
        exp_map        = '0;
        repeat (4) @(posedge clk_sys);
        #1;
        reset = 1'b0;

        reset_values_test();
        rom_set_test();
        ext_pages_test();
        combo_test();
        dandanator_test();
        backpressure_test();
        slave_error_test();

        $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures", tests_run,
                 tests_failed, errors, u_dut.u_queue.u_assert.fail_count);
        if (errors == 0 && u_dut.u_queue.u_assert.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
logic/cpc_loader_pkg.sv
logic/ext_page_decoder.sv
logic/boot_addr_mapper.sv
logic/boot_write_queue.sv
logic/cpc_image_loader.sv
testbench/cpc_image_loader_assert.sv
testbench/tb_cpc_image_loader.sv

//--- Bender.yml
package:
  name: cpc_image_loader

sources:
  # Package first, then the stages, then the top level
  - logic/cpc_loader_pkg.sv
  - logic/ext_page_decoder.sv
  - logic/boot_addr_mapper.sv
  - logic/boot_write_queue.sv
  - logic/cpc_image_loader.sv

  - target: test
    files:
      - testbench/cpc_image_loader_assert.sv
      - testbench/tb_cpc_image_loader.sv
